/* design/dds_lab_pkg.sv */
package dds_lab_pkg;

   //////////////////////////////
   // bus and lfsr widths
   //////////////////////////////
   localparam int AXIL_ADDR_W = 4;
   localparam int AXIL_DATA_W = 32;
   localparam int LFSR_W      = 5;

   typedef enum logic [1:0] {
      WAVE_SAW      = 2'd0,
      WAVE_SQUARE   = 2'd1,
      WAVE_TRIANGLE = 2'd2
   } wave_e;

   typedef enum logic [1:0] {
      MOD_NONE = 2'd0,
      MOD_ASK  = 2'd1,
      MOD_FSK  = 2'd2,
      MOD_BPSK = 2'd3
   } mod_e;

   typedef enum logic [1:0] {
      ST_IDLE       = 2'd0,
      ST_WRITE_RESP = 2'd1,
      ST_READ_DATA  = 2'd2
   } axil_state_e;

   // register map in byte offsets
   localparam logic [AXIL_ADDR_W-1:0] REG_CTRL     = 4'h0;  // wave 1..0, mod 3..2
   localparam logic [AXIL_ADDR_W-1:0] REG_TUNING   = 4'h4;
   localparam logic [AXIL_ADDR_W-1:0] REG_TICK_DIV = 4'h8;
   localparam logic [AXIL_ADDR_W-1:0] REG_STATUS   = 4'hC;  // read only

   localparam logic [LFSR_W-1:0] LFSR_SEED        = 5'b00001;
   localparam logic [31:0]       DEFAULT_TICK_DIV = 32'd25_000_000;  // 1 Hz at 25 MHz
   localparam logic [31:0]       DEFAULT_TUNING   = 32'h0000_0102;

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* design/ctrl_regs_axil.sv */
`timescale 1ns/1ps

module ctrl_regs_axil (
   input  logic                                 CLK_25MHZ,
   input  logic                                 reset_from_key,
   input  logic [dds_lab_pkg::AXIL_ADDR_W-1:0]  s_axil_awaddr,
   input  logic                                 s_axil_awvalid,
   output logic                                 s_axil_awready,
   input  logic [dds_lab_pkg::AXIL_DATA_W-1:0]  s_axil_wdata,
   input  logic                                 s_axil_wvalid,
   output logic                                 s_axil_wready,
   output logic [1:0]                           s_axil_bresp,
   output logic                                 s_axil_bvalid,
   input  logic                                 s_axil_bready,
   input  logic [dds_lab_pkg::AXIL_ADDR_W-1:0]  s_axil_araddr,
   input  logic                                 s_axil_arvalid,
   output logic                                 s_axil_arready,
   output logic [dds_lab_pkg::AXIL_DATA_W-1:0]  s_axil_rdata,
   output logic [1:0]                           s_axil_rresp,
   output logic                                 s_axil_rvalid,
   input  logic                                 s_axil_rready,
   input  logic [dds_lab_pkg::LFSR_W-1:0]       lfsr_value,
   output dds_lab_pkg::wave_e                   wave_sel,
   output dds_lab_pkg::mod_e                    mod_sel,
   output logic [dds_lab_pkg::AXIL_DATA_W-1:0]  tuning_word,
   output logic [dds_lab_pkg::AXIL_DATA_W-1:0]  tick_div,
   output logic                                 tick_div_write
);

   dds_lab_pkg::axil_state_e             state;
   logic [dds_lab_pkg::AXIL_DATA_W-1:0]  ctrl_reg;
   logic                                 wr_hs;
   logic                                 rd_hs;
   logic                                 wr_ok;

   // write takes priority when both channels are up
   assign wr_hs = (state == dds_lab_pkg::ST_IDLE) && s_axil_awvalid && s_axil_wvalid;
   assign rd_hs = (state == dds_lab_pkg::ST_IDLE) && s_axil_arvalid
                  && !(s_axil_awvalid && s_axil_wvalid);
   assign wr_ok = (s_axil_awaddr == dds_lab_pkg::REG_CTRL)
                  || (s_axil_awaddr == dds_lab_pkg::REG_TUNING)
                  || (s_axil_awaddr == dds_lab_pkg::REG_TICK_DIV);

   assign s_axil_awready = wr_hs;
   assign s_axil_wready  = wr_hs;
   assign s_axil_arready = rd_hs;
   assign s_axil_bvalid  = (state == dds_lab_pkg::ST_WRITE_RESP);
   assign s_axil_rvalid  = (state == dds_lab_pkg::ST_READ_DATA);

   assign wave_sel = dds_lab_pkg::wave_e'(ctrl_reg[1:0]);
   assign mod_sel  = dds_lab_pkg::mod_e'(ctrl_reg[3:2]);

   //////////////////////////////
   // fsm and config registers
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         state          <= dds_lab_pkg::ST_IDLE;
         ctrl_reg       <= '0;  // saw, no modulation
         tuning_word    <= dds_lab_pkg::DEFAULT_TUNING;
         tick_div       <= dds_lab_pkg::DEFAULT_TICK_DIV;
         tick_div_write <= 1'b0;
      end
      else
      begin
         tick_div_write <= 1'b0;
         case (state)
            dds_lab_pkg::ST_IDLE:
            begin
               if (wr_hs)
               begin
                  state <= dds_lab_pkg::ST_WRITE_RESP;
                  if (s_axil_awaddr == dds_lab_pkg::REG_CTRL)
                     ctrl_reg <= s_axil_wdata;
                  if (s_axil_awaddr == dds_lab_pkg::REG_TUNING)
                     tuning_word <= s_axil_wdata;
                  if (s_axil_awaddr == dds_lab_pkg::REG_TICK_DIV)
                  begin
                     tick_div       <= s_axil_wdata;
                     tick_div_write <= 1'b1;  // restarts the timer
                  end
               end
               else if (rd_hs)
                  state <= dds_lab_pkg::ST_READ_DATA;
            end
            dds_lab_pkg::ST_WRITE_RESP:
               if (s_axil_bready) state <= dds_lab_pkg::ST_IDLE;
            dds_lab_pkg::ST_READ_DATA:
               if (s_axil_rready) state <= dds_lab_pkg::ST_IDLE;
            default:
               state <= dds_lab_pkg::ST_IDLE;
         endcase
      end
   end

   // response payload captured at the handshake
   always_ff @(posedge CLK_25MHZ)
   begin
      if (wr_hs)
         s_axil_bresp <= wr_ok ? dds_lab_pkg::RESP_OKAY : dds_lab_pkg::RESP_SLVERR;
      if (rd_hs)
      begin
         s_axil_rresp <= dds_lab_pkg::RESP_OKAY;
         case (s_axil_araddr)
            dds_lab_pkg::REG_CTRL:     s_axil_rdata <= ctrl_reg;
            dds_lab_pkg::REG_TUNING:   s_axil_rdata <= tuning_word;
            dds_lab_pkg::REG_TICK_DIV: s_axil_rdata <= tick_div;
            dds_lab_pkg::REG_STATUS:
               s_axil_rdata <= {{(dds_lab_pkg::AXIL_DATA_W-dds_lab_pkg::LFSR_W){1'b0}},
                                lfsr_value};
            default:
            begin
               s_axil_rdata <= '0;
               s_axil_rresp <= dds_lab_pkg::RESP_SLVERR;
            end
         endcase
      end
   end

   // responses stay up under back-pressure
   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid && $stable(s_axil_bresp));
   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata));

endmodule

/* design/tick_timer.sv */
`timescale 1ns/1ps

module tick_timer (
   input  logic                                 CLK_25MHZ,
   input  logic                                 reset_from_key,
   input  logic [dds_lab_pkg::AXIL_DATA_W-1:0]  tick_div,
   input  logic                                 tick_div_write,
   output logic                                 tick
);

   logic [dds_lab_pkg::AXIL_DATA_W-1:0] count;
   logic [dds_lab_pkg::AXIL_DATA_W-1:0] reload;

   // divisors below 2 run as 2
   assign reload = (tick_div < 2) ? 1 : tick_div - 1;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key || tick_div_write)
      begin
         count <= reload;  // fresh period
         tick  <= 1'b0;
      end
      else if (count == '0)
      begin
         count <= reload;
         tick  <= 1'b1;
      end
      else
      begin
         count <= count - 1'b1;
         tick  <= 1'b0;
      end
   end

   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      tick |=> !tick);

endmodule

/* design/lfsr5.sv */
`timescale 1ns/1ps

module lfsr5 (
   input  logic                            CLK_25MHZ,
   input  logic                            reset_from_key,
   input  logic                            tick,
   output logic [dds_lab_pkg::LFSR_W-1:0]  lfsr_value
);

   logic feedback;

   // taps 4 and 2 give the full 31-state cycle
   assign feedback = lfsr_value[4] ^ lfsr_value[2];

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr_value <= dds_lab_pkg::LFSR_SEED;
      else if (tick)
         lfsr_value <= {lfsr_value[dds_lab_pkg::LFSR_W-2:0], feedback};
   end

   // all-zero would lock up
   assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr_value != '0);

endmodule

/* design/dds_core.sv */
`timescale 1ns/1ps

module dds_core #(
   parameter int PHASE_W  = 32,
   parameter int SAMPLE_W = 12
) (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  dds_lab_pkg::wave_e  wave_sel,
   input  logic [PHASE_W-1:0]  phase_inc,
   input  logic [PHASE_W-1:0]  phase_offset,
   output logic [SAMPLE_W-1:0] sample
);

   logic [PHASE_W-1:0]  phase_acc;
   logic [PHASE_W-1:0]  phase_sum;
   logic [SAMPLE_W-1:0] top_bits;
   logic [SAMPLE_W-1:0] doubled;
   logic [SAMPLE_W-1:0] shaped;

   //////////////////////////////
   // phase accumulator
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase_acc <= '0;
      else
         phase_acc <= phase_acc + phase_inc;  // wraps naturally
   end

   assign phase_sum = phase_acc + phase_offset;
   assign top_bits  = phase_sum[PHASE_W-1 -: SAMPLE_W];
   assign doubled   = {top_bits[SAMPLE_W-2:0], 1'b0};

   // carrier shaping
   always_comb
   begin
      case (wave_sel)
         dds_lab_pkg::WAVE_SQUARE:
            shaped = {SAMPLE_W{top_bits[SAMPLE_W-1]}};
         dds_lab_pkg::WAVE_TRIANGLE:
            shaped = top_bits[SAMPLE_W-1] ? ~doubled : doubled;  // falling half
         default:
            shaped = top_bits;  // saw and the spare code
      endcase
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      sample <= shaped;
   end

endmodule

/* design/modulator.sv */
`timescale 1ns/1ps

module modulator #(
   parameter int PHASE_W  = 32,
   parameter int SAMPLE_W = 12
) (
   input  logic                                 CLK_25MHZ,
   input  logic                                 reset_from_key,
   input  dds_lab_pkg::mod_e                    mod_sel,
   input  logic [dds_lab_pkg::AXIL_DATA_W-1:0]  tuning_word,
   input  logic                                 lfsr_bit,
   input  logic [SAMPLE_W-1:0]                  sample,
   output logic [PHASE_W-1:0]                   phase_inc,
   output logic [PHASE_W-1:0]                   phase_offset,
   output logic [SAMPLE_W-1:0]                  wave_out
);

   localparam logic [SAMPLE_W-1:0] MIDSCALE   = {1'b1, {(SAMPLE_W-1){1'b0}}};
   localparam logic [PHASE_W-1:0]  HALF_CYCLE = {1'b1, {(PHASE_W-1){1'b0}}};

   logic [PHASE_W-1:0] base_inc;
   logic               lfsr_bit_d;  // lines up with the dds sample

   assign base_inc = PHASE_W'(tuning_word);

   // fsk doubles the step, bpsk flips the phase
   assign phase_inc = (mod_sel == dds_lab_pkg::MOD_FSK && lfsr_bit) ? base_inc << 1
                                                                    : base_inc;
   assign phase_offset = (mod_sel == dds_lab_pkg::MOD_BPSK && lfsr_bit) ? HALF_CYCLE
                                                                        : '0;

   //////////////////////////////
   // output stage
   //////////////////////////////
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         lfsr_bit_d <= 1'b0;
         wave_out   <= MIDSCALE;
      end
      else
      begin
         lfsr_bit_d <= lfsr_bit;
         if (mod_sel == dds_lab_pkg::MOD_ASK && !lfsr_bit_d)
            wave_out <= MIDSCALE;  // carrier off
         else
            wave_out <= sample;
      end
   end

endmodule

/* design/dds_lab_top.sv */
`timescale 1ns/1ps

module dds_lab_top #(
   parameter int PHASE_W  = 32,
   parameter int SAMPLE_W = 12
) (
   input  logic                                 CLK_25MHZ,
   input  logic                                 reset_from_key,
   input  logic [dds_lab_pkg::AXIL_ADDR_W-1:0]  s_axil_awaddr,
   input  logic                                 s_axil_awvalid,
   output logic                                 s_axil_awready,
   input  logic [dds_lab_pkg::AXIL_DATA_W-1:0]  s_axil_wdata,
   input  logic                                 s_axil_wvalid,
   output logic                                 s_axil_wready,
   output logic [1:0]                           s_axil_bresp,
   output logic                                 s_axil_bvalid,
   input  logic                                 s_axil_bready,
   input  logic [dds_lab_pkg::AXIL_ADDR_W-1:0]  s_axil_araddr,
   input  logic                                 s_axil_arvalid,
   output logic                                 s_axil_arready,
   output logic [dds_lab_pkg::AXIL_DATA_W-1:0]  s_axil_rdata,
   output logic [1:0]                           s_axil_rresp,
   output logic                                 s_axil_rvalid,
   input  logic                                 s_axil_rready,
   output logic [SAMPLE_W-1:0]                  wave_out,
   output logic [dds_lab_pkg::LFSR_W-1:0]       lfsr_out,
   output logic                                 tick
);

   // configuration from the register block
   dds_lab_pkg::wave_e                   wave_sel;
   dds_lab_pkg::mod_e                    mod_sel;
   logic [dds_lab_pkg::AXIL_DATA_W-1:0]  tuning_word;
   logic [dds_lab_pkg::AXIL_DATA_W-1:0]  tick_div;
   logic                                 tick_div_write;

   // nco datapath
   logic [PHASE_W-1:0]   phase_inc;
   logic [PHASE_W-1:0]   phase_offset;
   logic [SAMPLE_W-1:0]  sample;

   ctrl_regs_axil i_ctrl_regs_axil (
      .lfsr_value (lfsr_out),
      .*
   );

   tick_timer i_tick_timer (.*);

   lfsr5 i_lfsr5 (
      .lfsr_value (lfsr_out),
      .*
   );

   dds_core #(
      .PHASE_W  (PHASE_W),
      .SAMPLE_W (SAMPLE_W)
   ) i_dds_core (.*);

   modulator #(
      .PHASE_W  (PHASE_W),
      .SAMPLE_W (SAMPLE_W)
   ) i_modulator (
      .lfsr_bit (lfsr_out[0]),  // modulating bit
      .*
   );

endmodule

/* tests/tb_dds_lab_tasks.svh */
`ifndef TB_DDS_LAB_TASKS_SVH
`define TB_DDS_LAB_TASKS_SVH

localparam int WAIT_LIMIT = 200;  // cycles per handshake wait

logic [31:0] rng_state;

// xorshift32 with its state in rng_state
function automatic logic [31:0] next_random();
   logic [31:0] x;
   x = rng_state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   rng_state = x;
   return x;
endfunction

task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
                          input int hold_b, output logic [1:0] resp);
   int n;
   @(negedge CLK_25MHZ);
   s_axil_awaddr  = addr;
   s_axil_wdata   = data;
   s_axil_awvalid = 1'b1;
   s_axil_wvalid  = 1'b1;
   s_axil_bready  = (hold_b == 0);
   n = 0;
   do
   begin
      @(posedge CLK_25MHZ);
      n++;
      if (n > WAIT_LIMIT) abort_run("write address/data handshake never completed");
   end while (!(s_axil_awready && s_axil_wready));
   @(negedge CLK_25MHZ);
   s_axil_awvalid = 1'b0;
   s_axil_wvalid  = 1'b0;
   // bvalid must hold while bready stays low
   for (int i = 0; i < hold_b; i++)
   begin
      @(posedge CLK_25MHZ);
      if (i > 0)
         assert (s_axil_bvalid) else report_mismatch("bvalid_hold", 1, s_axil_bvalid);
   end
   if (hold_b != 0)
   begin
      @(negedge CLK_25MHZ);
      s_axil_bready = 1'b1;
   end
   n = 0;
   do
   begin
      @(posedge CLK_25MHZ);
      n++;
      if (n > WAIT_LIMIT) abort_run("write response never arrived");
   end while (!s_axil_bvalid);
   resp = s_axil_bresp;
   @(negedge CLK_25MHZ);
   s_axil_bready = 1'b0;
endtask

task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
   int n;
   @(negedge CLK_25MHZ);
   s_axil_araddr  = addr;
   s_axil_arvalid = 1'b1;
   s_axil_rready  = 1'b1;
   n = 0;
   do
   begin
      @(posedge CLK_25MHZ);
      n++;
      if (n > WAIT_LIMIT) abort_run("read address handshake never completed");
   end while (!s_axil_arready);
   @(negedge CLK_25MHZ);
   s_axil_arvalid = 1'b0;
   n = 0;
   do
   begin
      @(posedge CLK_25MHZ);
      n++;
      if (n > WAIT_LIMIT) abort_run("read data never arrived");
   end while (!s_axil_rvalid);
   data = s_axil_rdata;
   resp = s_axil_rresp;
   @(negedge CLK_25MHZ);
   s_axil_rready = 1'b0;
endtask

`endif

/* tests/tb_dds_lab.sv */
`timescale 1ns/1ps

module tb_dds_lab;

   localparam int MODE_OFF = 0;
   localparam int MODE_SAW = 1;
   localparam int MODE_FSK = 2;
   localparam int MODE_SQUARE = 3;
   localparam int MODE_TRI = 4;
   localparam int MODE_BPSK = 5;
   localparam int MODE_ASK = 6;

   logic        CLK_25MHZ;
   logic        reset_from_key;
   logic [3:0]  s_axil_awaddr;
   logic        s_axil_awvalid;
   logic        s_axil_awready;
   logic [31:0] s_axil_wdata;
   logic        s_axil_wvalid;
   logic        s_axil_wready;
   logic [1:0]  s_axil_bresp;
   logic        s_axil_bvalid;
   logic        s_axil_bready;
   logic [3:0]  s_axil_araddr;
   logic        s_axil_arvalid;
   logic        s_axil_arready;
   logic [31:0] s_axil_rdata;
   logic [1:0]  s_axil_rresp;
   logic        s_axil_rvalid;
   logic        s_axil_rready;
   logic [11:0] wave_out;
   logic [4:0]  lfsr_out;
   logic        tick;

   // checker state
   int          chk_mode;
   int          since_tick;
   int          exp_div;
   bit          gap_on;
   longint      cyc;
   longint      last_tick;
   logic [31:0] cur_tuning;
   logic [4:0]  lfsr_model;
   logic [11:0] prev_wave;
   logic [11:0] bpsk_ref;
   bit          bpsk_ref_ok;

   dds_lab_top i_dds_lab_top (.*);

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic report_mismatch(input string name, input longint expv, input longint actv);
      $display("[FAIL] %s expected %0d actual %0d", name, expv, actv);
      $display("Simulation failed");
      $fatal(1, "check failed");
   endtask

   task automatic check_value(input string name, input longint expv, input longint actv);
      assert (expv == actv) else report_mismatch(name, expv, actv);
   endtask

   `include "tb_dds_lab_tasks.svh"

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;
   end

   //////////////////////////////
   // reference models
   //////////////////////////////
   always @(posedge CLK_25MHZ)
   begin
      logic [31:0] step;
      logic [11:0] k;
      logic [11:0] delta;
      int          diff;
      if (reset_from_key)
      begin
         lfsr_model = dds_lab_pkg::LFSR_SEED;
         since_tick = 0;
         cyc        = 0;
         last_tick  = -1;
      end
      else
      begin
         cyc++;
         check_value("lfsr_sequence", lfsr_model, lfsr_out);
         assert (lfsr_out != '0) else abort_run("lfsr reached the all-zero state");
         if (tick)
         begin
            if (gap_on && last_tick >= 0)
               assert (cyc - last_tick == exp_div)
                  else report_mismatch("tick_period", exp_div, cyc - last_tick);
            last_tick  = gap_on ? cyc : -1;
            lfsr_model = {lfsr_model[3:0], lfsr_model[4] ^ lfsr_model[2]};
            since_tick = 0;
         end
         else if (since_tick < 1000)
            since_tick++;
         // fsk doubles the step while the bit is set
         step  = (chk_mode == MODE_FSK && lfsr_out[0]) ? cur_tuning << 1 : cur_tuning;
         k     = step[31:20];
         delta = wave_out - prev_wave;
         diff  = (wave_out > prev_wave) ? wave_out - prev_wave : prev_wave - wave_out;
         if (chk_mode != MODE_OFF && since_tick >= 4)  // settle after each tick
         begin
            case (chk_mode)
               MODE_SAW, MODE_FSK:
                  assert (delta == k || delta == 12'(k + 12'd1))
                     else report_mismatch("saw_step", k, delta);
               MODE_ASK:
                  if (!lfsr_out[0])
                     check_value("ask_off_level", 2048, wave_out);
                  else
                     assert (delta == k || delta == 12'(k + 12'd1))
                        else report_mismatch("ask_on_step", k, delta);
               MODE_SQUARE:
                  assert (wave_out == 12'd0 || wave_out == 12'd4095)
                     else report_mismatch("square_level", 4095, wave_out);
               MODE_TRI:
                  assert (diff <= 2 * (k + 1))
                     else report_mismatch("triangle_step", 2 * (k + 1), diff);
               MODE_BPSK:
               begin
                  if (!bpsk_ref_ok && !lfsr_out[0])
                  begin
                     bpsk_ref    = wave_out;
                     bpsk_ref_ok = 1'b1;
                  end
                  if (bpsk_ref_ok)
                     check_value("bpsk_level", lfsr_out[0] ? bpsk_ref ^ 12'h800 : bpsk_ref,
                                 wave_out);
               end
               default: ;
            endcase
         end
         prev_wave = wave_out;
      end
   end

   task automatic configure(input dds_lab_pkg::mod_e m, input dds_lab_pkg::wave_e w,
                            input logic [31:0] tw);
      logic [1:0] resp;
      cur_tuning = tw;
      axil_write(dds_lab_pkg::REG_TUNING, tw, 0, resp);
      axil_write(dds_lab_pkg::REG_CTRL, (32'(m) << 2) | 32'(w), 0, resp);
   endtask

   task automatic run_mode(input int mode, input int cycles);
      repeat (8) @(negedge CLK_25MHZ);  // let the pipeline fill
      bpsk_ref_ok = 1'b0;
      chk_mode    = mode;
      repeat (cycles) @(negedge CLK_25MHZ);
      chk_mode = MODE_OFF;
   endtask

   //////////////////////////////
   // stimulus
   //////////////////////////////
   initial
   begin
      logic [31:0] data;
      logic [31:0] shadow [3];
      logic [1:0]  resp;
      logic [3:0]  addrs [3];
      reset_from_key = 1'b1;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      rng_state      = 32'd19;
      chk_mode       = MODE_OFF;
      gap_on         = 1'b0;
      exp_div        = 0;
      cur_tuning     = '0;
      prev_wave      = 12'd2048;
      addrs = '{dds_lab_pkg::REG_CTRL, dds_lab_pkg::REG_TUNING, dds_lab_pkg::REG_TICK_DIV};
      repeat (16) @(negedge CLK_25MHZ);
      reset_from_key = 1'b0;

      // register access with status first while no tick is due
      axil_read(dds_lab_pkg::REG_STATUS, data, resp);
      check_value("status_resp", dds_lab_pkg::RESP_OKAY, resp);
      check_value("status_value", 32'(lfsr_model), data);
      for (int i = 0; i < 6; i++)
      begin
         for (int r = 0; r < 3; r++)
         begin
            shadow[r] = next_random();
            axil_write(addrs[r], shadow[r], 0, resp);
            check_value("write_resp", dds_lab_pkg::RESP_OKAY, resp);
            axil_read(addrs[r], data, resp);
            check_value("read_resp", dds_lab_pkg::RESP_OKAY, resp);
            check_value("readback", shadow[r], data);
         end
      end
      axil_write(dds_lab_pkg::REG_STATUS, next_random(), 0, resp);
      check_value("status_write_resp", dds_lab_pkg::RESP_SLVERR, resp);
      axil_write(4'h2, next_random(), 3, resp);  // unmapped offset with bready held low
      check_value("unmapped_write_resp", dds_lab_pkg::RESP_SLVERR, resp);
      axil_read(4'h6, data, resp);
      check_value("unmapped_read_resp", dds_lab_pkg::RESP_SLVERR, resp);
      check_value("unmapped_read_data", 0, data);
      for (int r = 0; r < 3; r++)
      begin
         axil_read(addrs[r], data, resp);
         check_value("readback_after_slverr", shadow[r], data);
      end

      // tick period and carrier modes
      exp_div = 50;
      axil_write(dds_lab_pkg::REG_TICK_DIV, 32'd50, 0, resp);
      gap_on = 1'b1;
      configure(dds_lab_pkg::MOD_NONE, dds_lab_pkg::WAVE_SAW, next_random() >> 6);
      run_mode(MODE_SAW, 2500);
      configure(dds_lab_pkg::MOD_FSK, dds_lab_pkg::WAVE_SAW, next_random() >> 6);
      run_mode(MODE_FSK, 2500);
      configure(dds_lab_pkg::MOD_NONE, dds_lab_pkg::WAVE_SQUARE, next_random() >> 6);
      run_mode(MODE_SQUARE, 1500);
      configure(dds_lab_pkg::MOD_NONE, dds_lab_pkg::WAVE_TRIANGLE, next_random() >> 6);
      run_mode(MODE_TRI, 1500);
      configure(dds_lab_pkg::MOD_BPSK, dds_lab_pkg::WAVE_SAW, 32'd0);
      run_mode(MODE_BPSK, 2500);
      configure(dds_lab_pkg::MOD_ASK, dds_lab_pkg::WAVE_SAW, next_random() >> 6);
      run_mode(MODE_ASK, 2500);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

/* filelist.f */
+incdir+tests
design/dds_lab_pkg.sv
design/ctrl_regs_axil.sv
design/tick_timer.sv
design/lfsr5.sv
design/dds_core.sv
design/modulator.sv
design/dds_lab_top.sv
tests/tb_dds_lab.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dds_lab
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS    := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := tests/tb_dds_lab_tasks.svh
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
